//--- files.f
src/rv_pkg.sv
src/fd_xb_if.sv
src/instruction_decoder.sv
src/regfile.sv
src/fetch_decode.sv
src/xb_stage_reg.sv
src/execute_writeback.sv
src/core.sv
sim/core_asserts.sv
sim/core_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --assert --timing -Wno-fatal --top-module core_tb \
   -Mdir obj_dir -o core_sim -f files.f > build.log 2>&1 ||
   { echo "Build failed, see build.log"; exit 1; }
./obj_dir/core_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "\*\*\* TEST FAILED \*\*\*" sim.log && exit 1
grep -q "\*\*\* TEST PASSED \*\*\*" sim.log || exit 1
exit 0

//--- sim/core_asserts.sv
/* Concurrent checks on the FD memory port, fetch alignment and exception redirect */
`timescale 1ns/1ns
`default_nettype none

module core_checks #(
   parameter logic [31:0] EXC_VECTOR = 32'h0000_0004
) (
   input wire logic        clk,
   input wire logic        resetb,
   input wire logic [31:0] im_addr,
   input wire logic [31:0] pc,
   input wire logic        dm_we,
   input wire logic [3:0]  dm_be,
   input wire logic        exception
);

   int fail_count = 0;

   // Memory port quiet during reset
   a_reset_quiet: assert property (@(posedge clk) !resetb |-> (!dm_we && dm_be == 4'b0000))
      else begin $error("dm_we or dm_be active during reset"); fail_count++; end

   a_fetch_aligned: assert property (@(posedge clk) im_addr[1:0] == 2'b00)
      else begin $error("im_addr not word aligned"); fail_count++; end

   // Only aligned byte, half or word lanes
   a_be_pattern: assert property (@(posedge clk) disable iff (!resetb)
      dm_be != 4'b0000 |-> dm_be inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                         4'b0011, 4'b1100, 4'b1111})
      else begin $error("dm_be is not an aligned lane pattern"); fail_count++; end

   // FD holds the handler's first word one cycle later
   a_exc_arrive: assert property (@(posedge clk) disable iff (!resetb)
      exception |=> pc == EXC_VECTOR)
      else begin $error("PC not at the vector after exception"); fail_count++; end

endmodule

`default_nettype wire

//--- sim/core_tb.sv
/* Testbench for the two-stage core: clock, reset, memory models, generated
   test program with expected stores, timeout and result line */
`timescale 1ns/1ns
`default_nettype none

module core_tb import rv_pkg::*;;

   localparam logic [31:0] EXC_VEC = 32'h0000_0004;
   localparam logic [11:0] MARKER  = 12'h3F0;
   localparam logic [11:0] DONE    = 12'h3FC;

   logic        clk = 1'b0;
   logic        resetb;
   logic [31:0] im_addr, im_do, dm_addr, dm_di, dm_do;
   logic        dm_we, dm_is_signed;
   logic [3:0]  dm_be;

   logic [31:0] imem [0:255];
   logic [7:0]  dmem [0:1023];
   logic [31:0] exp_addr[$];
   logic [31:0] exp_data[$];
   logic [3:0]  exp_be[$];
   int          n_words = 0;
   int          slot = 0;
   int          exc_count = 0;
   int          st_idx = 0;
   int          store_errors = 0;
   int          load_errors = 0;
   int          other_errors = 0;
   int          seed = 60734;
   logic        done = 1'b0;

   core #(.RESET_VECTOR(32'h0), .EXC_VECTOR(EXC_VEC)) uut (
      .clk(clk), .resetb(resetb), .im_addr(im_addr), .im_do(im_do),
      .dm_addr(dm_addr), .dm_di(dm_di), .dm_do(dm_do), .dm_we(dm_we),
      .dm_be(dm_be), .dm_is_signed(dm_is_signed)
   );

   bind fetch_decode core_checks #(.EXC_VECTOR(EXC_VECTOR)) checks (
      .clk(clk), .resetb(resetb), .im_addr(im_addr), .pc(pc),
      .dm_we(dm_we), .dm_be(dm_be), .exception(exception)
   );

   always #20 clk = ~clk;

   // Instruction encoders
   function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, OPC_OP};
   endfunction

   function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
   endfunction

   function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
   endfunction

   function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
   endfunction

   // Reference results from the RV32I definitions
   function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
      input logic [31:0] a, input logic [31:0] b);
      case (f3)
         3'd0: return alt ? a - b : a + b;
         3'd1: return a << b[4:0];
         3'd2: return {31'd0, $signed(a) < $signed(b)};
         3'd3: return {31'd0, a < b};
         3'd4: return a ^ b;
         3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
         3'd6: return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
      input logic [31:0] b);
      case (f3)
         3'd0: return a == b;
         3'd1: return a != b;
         3'd4: return $signed(a) < $signed(b);
         3'd5: return $signed(a) >= $signed(b);
         3'd6: return a < b;
         default: return a >= b;
      endcase
   endfunction

   task automatic emit(input logic [31:0] w);
      imem[n_words] = w;
      n_words++;
   endtask

   task automatic expect_store(input logic [31:0] addr, input logic [3:0] be,
      input logic [31:0] data);
      exp_addr.push_back(addr);
      exp_be.push_back(be);
      exp_data.push_back(data);
   endtask

   // Store a register to its own result slot
   task automatic store_reg(input logic [4:0] rs, input logic [31:0] value);
      logic [11:0] off;
      off = 12'h200 + 12'(4 * slot);
      emit(s_type(off, rs, 5'd0, 3'd2));
      expect_store({20'd0, off}, 4'hF, value);
      slot++;
   endtask

   task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
      logic [31:0] upper;
      upper = (v + 32'h800) >> 12;
      emit({upper[19:0], rd, OPC_LUI});
      emit(i_type(v[11:0], rd, 3'd0, rd, OPC_OP_IMM));
   endtask

   // Branch over a marker store that only a not-taken branch executes
   task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
      input logic [4:0] rs2, input logic [31:0] a, input logic [31:0] b);
      emit(b_type(13'd8, rs2, rs1, f3));
      emit(s_type(MARKER, 5'd0, 5'd0, 3'd2));
      if (!branch_taken(f3, a, b))
         expect_store({20'd0, MARKER}, 4'hF, 32'd0);
   endtask

   // x30 holds the resume address for the handler
   task automatic fault_case(input logic [31:0] w);
      emit(i_type(12'((n_words + 2) * 4), 5'd0, 3'd0, 5'd30, OPC_OP_IMM));
      emit(w);
      exc_count++;
      expect_store(32'h0F0, 4'hF, 32'(exc_count));
   endtask

   task automatic build_program();
      logic [31:0] a, b, c;
      logic [11:0] imm;
      logic [4:0]  sh;
      int          p;
      a = $random(seed);
      b = $random(seed);
      c = $random(seed);
      imm = 12'($random(seed));
      sh = 5'($random(seed));
      for (int i = 0; i < 256; i++)
         imem[i] = {25'(i), 7'h00};
      for (int i = 0; i < 1024; i++)
         dmem[i] = 8'(i ^ (i >> 3) ^ 8'h96);
      emit(j_type(21'd16, 5'd0));
      // Exception handler at the vector
      emit(i_type(12'd1, 5'd29, 3'd0, 5'd29, OPC_OP_IMM));
      emit(s_type(12'h0F0, 5'd29, 5'd0, 3'd2));
      emit(i_type(12'd0, 5'd30, 3'd0, 5'd0, OPC_JALR));
      load_const(5'd1, a);
      load_const(5'd2, b);
      for (int f = 0; f < 8; f++) begin
         emit(r_type(7'd0, 5'd2, 5'd1, 3'(f), 5'd3));
         store_reg(5'd3, alu_result(3'(f), 1'b0, a, b));
      end
      emit(r_type(7'b0100000, 5'd2, 5'd1, 3'd0, 5'd3));
      store_reg(5'd3, alu_result(3'd0, 1'b1, a, b));
      emit(r_type(7'b0100000, 5'd2, 5'd1, 3'd5, 5'd3));
      store_reg(5'd3, alu_result(3'd5, 1'b1, a, b));
      for (int f = 0; f < 8; f++) begin
         if (f != 1 && f != 5) begin
            emit(i_type(imm, 5'd1, 3'(f), 5'd3, OPC_OP_IMM));
            store_reg(5'd3, alu_result(3'(f), 1'b0, a, {{20{imm[11]}}, imm}));
         end
      end
      emit(i_type({7'd0, sh}, 5'd1, 3'd1, 5'd3, OPC_OP_IMM));
      store_reg(5'd3, a << sh);
      emit(i_type({7'd0, sh}, 5'd1, 3'd5, 5'd3, OPC_OP_IMM));
      store_reg(5'd3, a >> sh);
      emit(i_type({7'b0100000, sh}, 5'd1, 3'd5, 5'd3, OPC_OP_IMM));
      store_reg(5'd3, $unsigned($signed(a) >>> sh));
      // Back-to-back dependency and load-use
      emit(i_type(12'd5, 5'd1, 3'd0, 5'd4, OPC_OP_IMM));
      emit(r_type(7'd0, 5'd4, 5'd4, 3'd0, 5'd5));
      store_reg(5'd5, (a + 32'd5) * 2);
      emit(s_type(12'h100, 5'd1, 5'd0, 3'd2));
      expect_store(32'h100, 4'hF, a);
      emit(i_type(12'h100, 5'd0, 3'd2, 5'd6, OPC_LOAD));
      emit(i_type(12'd1, 5'd6, 3'd0, 5'd7, OPC_OP_IMM));
      store_reg(5'd7, a + 32'd1);
      // Branches, then JAL and JALR with link checks
      branch_case(3'd0, 5'd1, 5'd1, a, a);
      branch_case(3'd1, 5'd1, 5'd1, a, a);
      branch_case(3'd0, 5'd1, 5'd2, a, b);
      branch_case(3'd1, 5'd1, 5'd2, a, b);
      for (int f = 4; f < 8; f++) begin
         branch_case(3'(f), 5'd1, 5'd2, a, b);
         branch_case(3'(f), 5'd2, 5'd1, b, a);
      end
      p = n_words * 4;
      emit(j_type(21'd8, 5'd8));
      emit(s_type(MARKER, 5'd0, 5'd0, 3'd2));
      store_reg(5'd8, 32'(p + 4));
      emit(i_type(12'((n_words + 3) * 4), 5'd0, 3'd0, 5'd9, OPC_OP_IMM));
      p = n_words * 4;
      // The odd offset loses its low bit in the JALR target
      emit(i_type(12'd1, 5'd9, 3'd0, 5'd10, OPC_JALR));
      emit(s_type(MARKER, 5'd0, 5'd0, 3'd2));
      store_reg(5'd10, 32'(p + 4));
      // Byte and halfword lanes, loads with extension
      load_const(5'd11, c);
      emit(s_type(12'h301, 5'd11, 5'd0, 3'd0));
      expect_store(32'h301, 4'b0010, {4{c[7:0]}});
      emit(s_type(12'h306, 5'd11, 5'd0, 3'd1));
      expect_store(32'h306, 4'b1100, {2{c[15:0]}});
      emit(i_type(12'h301, 5'd0, 3'b000, 5'd12, OPC_LOAD));
      store_reg(5'd12, {{24{c[7]}}, c[7:0]});
      emit(i_type(12'h301, 5'd0, 3'b100, 5'd12, OPC_LOAD));
      store_reg(5'd12, {24'd0, c[7:0]});
      emit(i_type(12'h306, 5'd0, 3'b001, 5'd12, OPC_LOAD));
      store_reg(5'd12, {{16{c[15]}}, c[15:0]});
      emit(i_type(12'h306, 5'd0, 3'b101, 5'd12, OPC_LOAD));
      store_reg(5'd12, {16'd0, c[15:0]});
      // Illegal funct7 and misaligned LW leave their rd untouched
      fault_case(r_type(7'b0000001, 5'd2, 5'd1, 3'd0, 5'd13));
      store_reg(5'd13, 32'd0);
      fault_case(i_type(12'h102, 5'd0, 3'd2, 5'd14, OPC_LOAD));
      store_reg(5'd14, 32'd0);
      emit(s_type(DONE, 5'd0, 5'd0, 3'd2));
      expect_store({20'd0, DONE}, 4'hF, 32'd0);
      emit(j_type(21'd0, 5'd0));
   endtask

   task automatic check_store();
      if (st_idx >= exp_addr.size()) begin
         $display("Unexpected store to address %h at %0t", dm_addr, $time);
         store_errors++;
      end else begin
         assert (dm_addr == exp_addr[st_idx]) else begin
            $display("[ERROR] %0t dm_addr expected %h actual %h", $time,
                     exp_addr[st_idx], dm_addr);
            store_errors++;
         end
         assert (dm_be == exp_be[st_idx]) else begin
            $display("[ERROR] %0t dm_be expected %b actual %b", $time, exp_be[st_idx], dm_be);
            store_errors++;
         end
         assert (dm_di == exp_data[st_idx]) else begin
            $display("[ERROR] %0t dm_di expected %h actual %h", $time,
                     exp_data[st_idx], dm_di);
            store_errors++;
         end
         st_idx++;
      end
   endtask

   // Loads with funct3 bit 2 set are the unsigned kinds
   task automatic check_load_sign();
      logic exp_signed;
      exp_signed = ~im_do[14];
      assert (dm_is_signed == exp_signed) else begin
         $display("[ERROR] %0t dm_is_signed expected %b actual %b", $time, exp_signed,
                  dm_is_signed);
         load_errors++;
      end
   endtask

   // Both memories answer one cycle after the address
   always @(posedge clk) begin
      im_do <= imem[im_addr[9:2]];
      dm_do <= {dmem[{dm_addr[9:2], 2'd3}], dmem[{dm_addr[9:2], 2'd2}],
                dmem[{dm_addr[9:2], 2'd1}], dmem[{dm_addr[9:2], 2'd0}]};
      if (resetb && !dm_we && dm_be != 4'b0000)
         check_load_sign();
      if (resetb && dm_we) begin
         check_store();
         for (int k = 0; k < 4; k++)
            if (dm_be[k])
               dmem[{dm_addr[9:2], 2'(k)}] <= dm_di[8*k +: 8];
         if (dm_addr == {20'd0, DONE})
            done <= 1'b1;
      end
   end

   initial begin
      int cycles;
      int limit;
      resetb = 1'b0;
      im_do = 32'd0;
      dm_do = 32'd0;
      cycles = 0;
      build_program();
      limit = 3 * n_words + 50;
      repeat (5) @(posedge clk);
      resetb <= 1'b1;
      while (!done && cycles < limit) begin
         @(posedge clk);
         cycles++;
      end
      if (!done) begin
         $display("Timeout: the final store was not seen within %0d cycles", limit);
         other_errors++;
      end
      if (st_idx != exp_addr.size()) begin
         $display("Only %0d of %0d expected stores were seen", st_idx, exp_addr.size());
         other_errors++;
      end
      @(posedge clk);
      $display("Errors: store=%0d load=%0d assertion=%0d other=%0d", store_errors,
               load_errors, uut.u_fd.checks.fail_count, other_errors);
      if (store_errors == 0 && load_errors == 0 && other_errors == 0 &&
          uut.u_fd.checks.fail_count == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- src/core.sv
/* Two-stage RV32I core: FD stage, register file, stage register and XB stage */
`timescale 1ns/1ns
`default_nettype none

module core #(
   parameter logic [31:0] RESET_VECTOR = 32'h0000_0000,
   parameter logic [31:0] EXC_VECTOR   = 32'h0000_0004
) (
   input  wire logic        clk,
   input  wire logic        resetb,
   output logic [31:0]      im_addr,
   input  wire logic [31:0] im_do,
   output logic [31:0]      dm_addr,
   output logic [31:0]      dm_di,
   input  wire logic [31:0] dm_do,
   output logic             dm_we,
   output logic [3:0]       dm_be,
   output logic             dm_is_signed
);

   logic [4:0]  a_rs1, a_rs2, a_rd;
   logic [31:0] d_rs1, d_rs2, d_rd;
   logic        we_rd;
   logic        bubble;

   fd_xb_if fd_q ();
   fd_xb_if xb_d ();

   fetch_decode #(.RESET_VECTOR(RESET_VECTOR), .EXC_VECTOR(EXC_VECTOR)) u_fd (
      .clk(clk), .resetb(resetb),
      .im_addr(im_addr), .im_do(im_do),
      .dm_addr(dm_addr), .dm_di(dm_di), .dm_we(dm_we), .dm_be(dm_be),
      .dm_is_signed(dm_is_signed),
      .a_rs1(a_rs1), .a_rs2(a_rs2), .d_rs1(d_rs1), .d_rs2(d_rs2),
      .bubble(bubble), .q(fd_q.src)
   );

   regfile u_rf (
      .clk(clk), .resetb(resetb),
      .a_rs1(a_rs1), .a_rs2(a_rs2), .d_rs1(d_rs1), .d_rs2(d_rs2),
      .a_rd(a_rd), .d_rd(d_rd), .we_rd(we_rd)
   );

   xb_stage_reg u_xb_reg (
      .clk(clk), .resetb(resetb), .bubble(bubble),
      .d(fd_q.buf_in), .q(xb_d.buf_out)
   );

   execute_writeback u_xb (
      .d(xb_d.dst), .dm_do(dm_do),
      .a_rd(a_rd), .d_rd(d_rd), .we_rd(we_rd)
   );

endmodule

`default_nettype wire

//--- src/execute_writeback.sv
/* XB stage: operand select, ALU, load alignment and extension, writeback mux */
`timescale 1ns/1ns
`default_nettype none

module execute_writeback import rv_pkg::*; (
   fd_xb_if.dst             d,
   input  wire logic [31:0] dm_do,
   output logic [4:0]       a_rd,
   output logic [31:0]      d_rd,
   output logic             we_rd
);

   logic [31:0] op1, op2, alu_out;
   logic [31:0] ld_shift, ld_data;

   always_comb begin
      case (d.ctrl.op1_sel)
         OP1_PC:   op1 = d.pc;
         OP1_ZERO: op1 = 32'd0;
         default:  op1 = d.rs1;
      endcase
      op2 = (d.ctrl.op2_sel == OP2_IMM) ? d.imm : d.rs2;
   end

   // Shift amount is the low five bits of the second operand
   always_comb begin
      case (d.ctrl.alu_op)
         ALU_ADD:    alu_out = op1 + op2;
         ALU_SUB:    alu_out = op1 - op2;
         ALU_SLT:    alu_out = {31'd0, $signed(op1) < $signed(op2)};
         ALU_SLTU:   alu_out = {31'd0, op1 < op2};
         ALU_AND:    alu_out = op1 & op2;
         ALU_OR:     alu_out = op1 | op2;
         ALU_XOR:    alu_out = op1 ^ op2;
         ALU_SLL:    alu_out = op1 << op2[4:0];
         ALU_SRL:    alu_out = op1 >> op2[4:0];
         ALU_SRA:    alu_out = $unsigned($signed(op1) >>> op2[4:0]);
         ALU_PASS_B: alu_out = op2;
         default:    alu_out = 32'd0;
      endcase
   end

   // Bring the addressed lane down to bit 0
   assign ld_shift = dm_do >> {d.ctrl.byte_off, 3'b000};

   always_comb begin
      case (d.ctrl.load_kind)
         LD_B:    ld_data = {{24{ld_shift[7]}}, ld_shift[7:0]};
         LD_BU:   ld_data = {24'd0, ld_shift[7:0]};
         LD_H:    ld_data = {{16{ld_shift[15]}}, ld_shift[15:0]};
         LD_HU:   ld_data = {16'd0, ld_shift[15:0]};
         default: ld_data = ld_shift;
      endcase
   end

   always_comb begin
      case (d.ctrl.wb_sel)
         WB_MEM:  d_rd = ld_data;
         WB_PC4:  d_rd = d.pc + 32'd4;
         default: d_rd = alu_out;
      endcase
   end

   assign a_rd  = d.ctrl.rd;
   assign we_rd = d.ctrl.regwrite;

endmodule

`default_nettype wire

//--- src/fd_xb_if.sv
/* One instruction's payload travelling from FD through the stage register to XB */
`timescale 1ns/1ns
`default_nettype none

interface fd_xb_if import rv_pkg::*; ();

   xb_ctrl_t    ctrl;
   logic [31:0] pc;
   logic [31:0] rs1;
   logic [31:0] rs2;
   logic [31:0] imm;

   // FD side
   modport src     (output ctrl, pc, rs1, rs2, imm);
   // Stage register, input and output halves
   modport buf_in  (input  ctrl, pc, rs1, rs2, imm);
   modport buf_out (output ctrl, pc, rs1, rs2, imm);
   // XB side
   modport dst     (input  ctrl, pc, rs1, rs2, imm);

endinterface

`default_nettype wire

//--- src/fetch_decode.sv
/* FD stage: PC and next-PC choice, branch resolution, data-memory request,
   exception detection and bubble */
`timescale 1ns/1ns
`default_nettype none

module fetch_decode import rv_pkg::*; #(
   parameter logic [31:0] RESET_VECTOR = 32'h0000_0000,
   parameter logic [31:0] EXC_VECTOR   = 32'h0000_0004
) (
   input  wire logic        clk,
   input  wire logic        resetb,
   output logic [31:0]      im_addr,
   input  wire logic [31:0] im_do,
   output logic [31:0]      dm_addr,
   output logic [31:0]      dm_di,
   output logic             dm_we,
   output logic [3:0]       dm_be,
   output logic             dm_is_signed,
   output logic [4:0]       a_rs1,
   output logic [4:0]       a_rs2,
   input  wire logic [31:0] d_rs1,
   input  wire logic [31:0] d_rs2,
   output logic             bubble,
   fd_xb_if.src             q
);

   logic [31:0] pc, next_pc, immediate, br_target, jalr_target, target;
   logic        fd_valid;
   xb_ctrl_t    ctrl;
   logic        is_branch, is_jal, is_jalr, is_store, is_load, illegal;
   logic [2:0]  branch_funct;
   logic [1:0]  store_size;
   logic        taken, redirect, mem_misaligned, tgt_misaligned, exception;
   logic [3:0]  lanes;

   instruction_decoder u_dec (
      .inst(im_do), .ctrl(ctrl), .immediate(immediate),
      .a_rs1(a_rs1), .a_rs2(a_rs2),
      .is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr),
      .branch_funct(branch_funct), .is_store(is_store),
      .store_size(store_size), .illegal(illegal)
   );

   // Branch compare
   always_comb begin
      case (branch_funct)
         3'b000:  taken = (d_rs1 == d_rs2);
         3'b001:  taken = (d_rs1 != d_rs2);
         3'b100:  taken = ($signed(d_rs1) < $signed(d_rs2));
         3'b101:  taken = ($signed(d_rs1) >= $signed(d_rs2));
         3'b110:  taken = (d_rs1 < d_rs2);
         default: taken = (d_rs1 >= d_rs2);
      endcase
   end

   assign dm_addr     = d_rs1 + immediate;
   assign br_target   = pc + immediate;
   assign jalr_target = {dm_addr[31:1], 1'b0};
   assign redirect    = is_jal | is_jalr | (is_branch & taken);
   assign target      = is_jalr ? jalr_target : br_target;

   // Access size and misalignment
   assign is_load  = (ctrl.wb_sel == WB_MEM);
   assign mem_misaligned = (is_load | is_store) &
                           ((store_size == 2'd1 && dm_addr[0]) ||
                            (store_size == 2'd2 && dm_addr[1:0] != 2'b00));
   assign tgt_misaligned = redirect & (target[1:0] != 2'b00);
   assign exception = fd_valid & (illegal | mem_misaligned | tgt_misaligned);
   assign bubble    = ~fd_valid | exception;

   // Lane strobes and replicated store data
   always_comb begin
      case (store_size)
         2'd0:    lanes = 4'b0001 << dm_addr[1:0];
         2'd1:    lanes = 4'b0011 << dm_addr[1:0];
         default: lanes = 4'b1111;
      endcase
      case (store_size)
         2'd0:    dm_di = {4{d_rs2[7:0]}};
         2'd1:    dm_di = {2{d_rs2[15:0]}};
         default: dm_di = d_rs2;
      endcase
   end

   assign dm_we        = ~bubble & is_store;
   assign dm_be        = (~bubble & (is_store | is_load)) ? lanes : 4'b0000;
   assign dm_is_signed = ~ctrl.load_kind[2];

   always_comb begin
      if (!fd_valid)
         next_pc = pc;
      else if (exception)
         next_pc = EXC_VECTOR;
      else if (redirect)
         next_pc = target;
      else
         next_pc = pc + 32'd4;
   end
   assign im_addr = next_pc;

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         pc       <= RESET_VECTOR;
         fd_valid <= 1'b0;
      end else begin
         pc       <= next_pc;
         fd_valid <= 1'b1;
      end
   end

   // Payload toward XB with the byte offset known only here
   always_comb begin
      q.ctrl          = ctrl;
      q.ctrl.byte_off = dm_addr[1:0];
   end
   assign q.pc  = pc;
   assign q.rs1 = d_rs1;
   assign q.rs2 = d_rs2;
   assign q.imm = immediate;

endmodule

`default_nettype wire

//--- src/instruction_decoder.sv
/* Combinational RV32I decoder: control word, immediate, branch and store info,
   and the illegal-instruction flag */
`timescale 1ns/1ns
`default_nettype none

module instruction_decoder import rv_pkg::*; (
   input  wire logic [31:0] inst,
   output xb_ctrl_t         ctrl,
   output logic [31:0]      immediate,
   output logic [4:0]       a_rs1,
   output logic [4:0]       a_rs2,
   output logic             is_branch,
   output logic             is_jal,
   output logic             is_jalr,
   output logic [2:0]       branch_funct,
   output logic             is_store,
   output logic [1:0]       store_size,
   output logic             illegal
);

   logic [6:0]  opcode;
   logic [2:0]  funct3;
   logic [6:0]  funct7;
   logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;

   assign opcode = inst[6:0];
   assign funct3 = inst[14:12];
   assign funct7 = inst[31:25];
   assign a_rs1  = inst[19:15];
   assign a_rs2  = inst[24:20];
   assign branch_funct = funct3;
   assign store_size   = funct3[1:0];

   // Immediate formats
   assign imm_i = {{20{inst[31]}}, inst[31:20]};
   assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
   assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
   assign imm_u = {inst[31:12], 12'b0};
   assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

   always_comb begin
      ctrl = '{alu_op: ALU_ADD, op1_sel: OP1_RS1, op2_sel: OP2_RS2, load_kind: LD_W,
               wb_sel: WB_ALU, rd: inst[11:7], regwrite: 1'b0, byte_off: 2'b00};
      immediate = imm_i;
      is_branch = 1'b0;
      is_jal    = 1'b0;
      is_jalr   = 1'b0;
      is_store  = 1'b0;
      illegal   = 1'b0;
      case (opcode)
         OPC_OP, OPC_OP_IMM: begin
            ctrl.regwrite = 1'b1;
            ctrl.op2_sel  = (opcode == OPC_OP) ? OP2_RS2 : OP2_IMM;
            case (funct3)
               3'b000: ctrl.alu_op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
               3'b001: ctrl.alu_op = ALU_SLL;
               3'b010: ctrl.alu_op = ALU_SLT;
               3'b011: ctrl.alu_op = ALU_SLTU;
               3'b100: ctrl.alu_op = ALU_XOR;
               3'b101: ctrl.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
               3'b110: ctrl.alu_op = ALU_OR;
               default: ctrl.alu_op = ALU_AND;
            endcase
            // funct7 is only free for immediate ops other than shifts
            if (opcode == OPC_OP || funct3 == 3'b001 || funct3 == 3'b101) begin
               if (funct7 != 7'b0000000 &&
                   !(funct7 == 7'b0100000 && (funct3 == 3'b101 ||
                     (funct3 == 3'b000 && opcode == OPC_OP))))
                  illegal = 1'b1;
            end
         end
         OPC_LUI: begin
            ctrl.regwrite = 1'b1;
            ctrl.op1_sel  = OP1_ZERO;
            ctrl.op2_sel  = OP2_IMM;
            ctrl.alu_op   = ALU_PASS_B;
            immediate     = imm_u;
         end
         OPC_AUIPC: begin
            ctrl.regwrite = 1'b1;
            ctrl.op1_sel  = OP1_PC;
            ctrl.op2_sel  = OP2_IMM;
            immediate     = imm_u;
         end
         OPC_LOAD: begin
            ctrl.regwrite  = 1'b1;
            ctrl.wb_sel    = WB_MEM;
            ctrl.load_kind = load_kind_t'(funct3);
            if (funct3 == 3'b011 || funct3[2:1] == 2'b11)
               illegal = 1'b1;
         end
         OPC_STORE: begin
            is_store  = 1'b1;
            immediate = imm_s;
            if (funct3[2] || funct3[1:0] == 2'b11)
               illegal = 1'b1;
         end
         OPC_BRANCH: begin
            is_branch = 1'b1;
            immediate = imm_b;
            if (funct3[2:1] == 2'b01)
               illegal = 1'b1;
         end
         OPC_JAL: begin
            is_jal        = 1'b1;
            ctrl.regwrite = 1'b1;
            ctrl.wb_sel   = WB_PC4;
            immediate     = imm_j;
         end
         OPC_JALR: begin
            is_jalr       = 1'b1;
            ctrl.regwrite = 1'b1;
            ctrl.wb_sel   = WB_PC4;
            if (funct3 != 3'b000)
               illegal = 1'b1;
         end
         default: illegal = 1'b1;
      endcase
   end

endmodule

`default_nettype wire

//--- src/regfile.sv
/* x1..x31 register file with x0 tied to zero and write-to-read bypass */
`timescale 1ns/1ns
`default_nettype none

module regfile (
   input  wire logic        clk,
   input  wire logic        resetb,
   input  wire logic [4:0]  a_rs1,
   input  wire logic [4:0]  a_rs2,
   output logic [31:0]      d_rs1,
   output logic [31:0]      d_rs2,
   input  wire logic [4:0]  a_rd,
   input  wire logic [31:0] d_rd,
   input  wire logic        we_rd
);

   logic [31:0] regs [1:31];

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         for (int i = 1; i < 32; i++)
            regs[i] <= 32'd0;
      end else if (we_rd && a_rd != 5'd0) begin
         regs[a_rd] <= d_rd;
      end
   end

   // Same-cycle XB write is visible to the FD read
   always_comb begin
      if (a_rs1 == 5'd0)
         d_rs1 = 32'd0;
      else if (we_rd && a_rs1 == a_rd)
         d_rs1 = d_rd;
      else
         d_rs1 = regs[a_rs1];

      if (a_rs2 == 5'd0)
         d_rs2 = 32'd0;
      else if (we_rd && a_rs2 == a_rd)
         d_rs2 = d_rd;
      else
         d_rs2 = regs[a_rs2];
   end

endmodule

`default_nettype wire

//--- src/rv_pkg.sv
/* Shared RV32I definitions: major opcodes, ALU, operand, load and writeback
   encodings, and the control word carried from FD to XB */
`default_nettype none

package rv_pkg;

   // Major opcodes of the supported instruction classes
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;
   localparam logic [6:0] OPC_JALR   = 7'b1100111;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR,
      ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_B
   } alu_op_t;

   typedef enum logic {OP2_RS2, OP2_IMM} op2_sel_t;

   typedef enum logic [1:0] {OP1_RS1, OP1_PC, OP1_ZERO} op1_sel_t;

   // Same encoding as the load funct3 field
   typedef enum logic [2:0] {
      LD_B  = 3'b000,
      LD_H  = 3'b001,
      LD_W  = 3'b010,
      LD_BU = 3'b100,
      LD_HU = 3'b101
   } load_kind_t;

   typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_t;

   typedef struct packed {
      alu_op_t    alu_op;
      op1_sel_t   op1_sel;
      op2_sel_t   op2_sel;
      load_kind_t load_kind;
      wb_sel_t    wb_sel;
      logic [4:0] rd;
      logic       regwrite;
      logic [1:0] byte_off;
   } xb_ctrl_t;

endpackage

`default_nettype wire

//--- src/xb_stage_reg.sv
/* FD-to-XB pipeline register; a bubble enters XB with regwrite cleared */
`timescale 1ns/1ns
`default_nettype none

module xb_stage_reg import rv_pkg::*; (
   input  wire logic clk,
   input  wire logic resetb,
   input  wire logic bubble,
   fd_xb_if.buf_in   d,
   fd_xb_if.buf_out  q
);

   xb_ctrl_t ctrl_r;
   logic     regwrite_r;

   // Side-effect control
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb)
         regwrite_r <= 1'b0;
      else if (bubble)
         regwrite_r <= 1'b0;
      else
         regwrite_r <= d.ctrl.regwrite;
   end

   // Pure controls and operands
   always_ff @(posedge clk) begin
      ctrl_r <= d.ctrl;
      q.pc   <= d.pc;
      q.rs1  <= d.rs1;
      q.rs2  <= d.rs2;
      q.imm  <= d.imm;
   end

   always_comb begin
      q.ctrl          = ctrl_r;
      q.ctrl.regwrite = regwrite_r;
   end

endmodule

`default_nettype wire
